// File: logic/xdma_defs.svh
// xdma adapter parameters
// widths, address map and mailbox slot layout shared by rtl and testbench

`ifndef XDMA_DEFS_SVH
`define XDMA_DEFS_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define XDMA_ADDR_W         48
`define XDMA_DATA_W         128
`define XDMA_ID_W           8
`define XDMA_LEN_W          16

// ----------------------------------------------------------------------
// system address map
// ----------------------------------------------------------------------
`define XDMA_CLUSTER_BASE   48'h0000_1000_0000
`define XDMA_CLUSTER_SPACE  48'h0000_0010_0000
// log2 of the cluster space
`define XDMA_CLUSTER_SHIFT  20
`define XDMA_MAINMEM_BASE   48'h0000_8000_0000
`define XDMA_MAINMEM_END    48'h0001_0000_0000

// mailbox region is 16 KB at the top of each window, four slots
`define XDMA_SLOT_BYTES     4096
`define XDMA_SLOT_DATA      0
`define XDMA_SLOT_CFG       1

`endif

// File: logic/xdma_pkg.sv
// xdma adapter package
// vector types, beat and header structs, and the mailbox address rule

`default_nettype none

`include "xdma_defs.svh"

package xdma_pkg;

  typedef logic [`XDMA_ADDR_W-1:0] addr_t;
  typedef logic [`XDMA_DATA_W-1:0] word_t;
  typedef logic [`XDMA_ID_W-1:0]   dma_id_t;
  typedef logic [`XDMA_LEN_W-1:0]  len_t;

  // first beat of a configuration message, fills one word exactly
  typedef struct packed {
    logic [6:0] pad;
    addr_t      reader_addr;
    addr_t      writer_addr;
    dma_id_t    dma_id;
    len_t       frame_length;
    // 0 read, 1 write
    logic       dma_type;
  } cfg_header_t;

  // sideband held for a whole payload message
  typedef struct packed {
    addr_t dst_addr;
    len_t  dma_length;
  } data_cfg_t;

  // one write beat on any stream
  typedef struct packed {
    addr_t addr;
    word_t data;
    logic  last;
  } beat_t;

  typedef enum logic {
    CFG_HEADER,
    CFG_BODY
  } cfg_state_e;

  // mailbox slot address of the window that holds target
  function automatic addr_t mailbox_addr(addr_t target, int unsigned slot);
    addr_t cluster_num;
    addr_t region_end;
    if (target >= `XDMA_MAINMEM_BASE) begin
      region_end = `XDMA_MAINMEM_END;
    end else begin
      cluster_num = (target - `XDMA_CLUSTER_BASE) >> `XDMA_CLUSTER_SHIFT;
      region_end  = `XDMA_CLUSTER_BASE + `XDMA_CLUSTER_SPACE * (cluster_num + 1'b1);
    end
    // slots counted downward from the region end
    return region_end - addr_t'((slot + 1) * `XDMA_SLOT_BYTES);
  endfunction

endpackage

`default_nettype wire

// File: logic/xdma_cfg_framer.sv
// outgoing configuration framer
// finds the header of each message, tags all its beats with the remote cfg mailbox

`timescale 1ns/10ps
`default_nettype none

`include "xdma_defs.svh"

module xdma_cfg_framer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  xdma_pkg::word_t cfg_i,
  input  logic            cfg_valid_i,
  output logic            cfg_ready_o,
  output xdma_pkg::beat_t beat_o,
  output logic            beat_valid_o,
  input  logic            beat_ready_i
);
  import xdma_pkg::*;

  cfg_state_e  state_q, state_d;
  len_t        cnt_q, cnt_d;
  len_t        len_q;
  addr_t       addr_q;
  cfg_header_t hdr;
  addr_t       target;
  addr_t       hdr_addr;
  logic        xfer;

  // ----------------------------------------------------------------------
  // header decode
  // ----------------------------------------------------------------------
  assign hdr = cfg_header_t'(cfg_i);
  // write task names the writer as remote side, read task the reader
  assign target   = hdr.dma_type ? hdr.writer_addr : hdr.reader_addr;
  assign hdr_addr = mailbox_addr(target, `XDMA_SLOT_CFG);

  // pass through, no buffering
  assign beat_valid_o = cfg_valid_i;
  assign cfg_ready_o  = beat_ready_i;
  assign xfer         = cfg_valid_i & beat_ready_i;

  // ----------------------------------------------------------------------
  // beat tagging and frame counting
  // ----------------------------------------------------------------------
  always_comb begin
    beat_o.data = cfg_i;
    state_d     = state_q;
    cnt_d       = cnt_q;
    case (state_q)
      CFG_BODY: begin
        beat_o.addr = addr_q;
        beat_o.last = (cnt_q == len_t'(len_q - 1'b1));
        if (xfer) begin
          if (beat_o.last) begin
            state_d = CFG_HEADER;
            cnt_d   = '0;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      default: begin
        beat_o.addr = hdr_addr;
        // lengths 0 and 1 both mean header only
        beat_o.last = (hdr.frame_length <= 1);
        if (xfer && !beat_o.last) begin
          state_d = CFG_BODY;
          // header counts as beat zero
          cnt_d   = len_t'(1);
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CFG_HEADER;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // message length and mailbox, held for the body beats
  always_ff @(posedge clk_i) begin
    if (state_q == CFG_HEADER && xfer && !beat_o.last) begin
      len_q  <= hdr.frame_length;
      addr_q <= hdr_addr;
    end
  end

endmodule

`default_nettype wire

// File: logic/xdma_data_framer.sv
// outgoing payload framer
// tags payload beats with the remote data mailbox and marks the message end

`timescale 1ns/10ps
`default_nettype none

`include "xdma_defs.svh"

module xdma_data_framer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  xdma_pkg::word_t     data_i,
  input  xdma_pkg::data_cfg_t data_cfg_i,
  input  logic                data_valid_i,
  output logic                data_ready_o,
  output xdma_pkg::beat_t     beat_o,
  output logic                beat_valid_o,
  input  logic                beat_ready_i
);
  import xdma_pkg::*;

  len_t cnt_q;
  logic xfer;

  assign beat_valid_o = data_valid_i;
  assign data_ready_o = beat_ready_i;
  assign xfer         = data_valid_i & beat_ready_i;

  // same mailbox for every beat, dst_addr held for the message
  assign beat_o.addr = mailbox_addr(data_cfg_i.dst_addr, `XDMA_SLOT_DATA);
  assign beat_o.data = data_i;
  // zero length is treated as a single beat
  assign beat_o.last = (data_cfg_i.dma_length <= 1) ||
                       (cnt_q == len_t'(data_cfg_i.dma_length - 1'b1));

  // beats accepted so far in this message
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (xfer) begin
      cnt_q <= beat_o.last ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/xdma_tx_arbiter.sv
// outgoing stream merge
// round-robin between cfg and data framers, one whole message at a time

`timescale 1ns/10ps
`default_nettype none

module xdma_tx_arbiter (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  xdma_pkg::beat_t cfg_beat_i,
  input  xdma_pkg::beat_t data_beat_i,
  input  logic            cfg_valid_i,
  input  logic            data_valid_i,
  output logic            cfg_ready_o,
  output logic            data_ready_o,
  output xdma_pkg::beat_t tx_o,
  output logic            tx_valid_o,
  input  logic            tx_ready_i
);

  // source encoding: 0 cfg, 1 data
  logic locked_q;
  logic lock_src_q;
  logic prio_q;
  logic sel;

  // ----------------------------------------------------------------------
  // grant
  // ----------------------------------------------------------------------
  always_comb begin
    if (locked_q) begin
      sel = lock_src_q;
    end else if (cfg_valid_i && data_valid_i) begin
      sel = prio_q;
    end else begin
      // only one or none requesting
      sel = data_valid_i;
    end
  end

  assign tx_o         = sel ? data_beat_i : cfg_beat_i;
  assign tx_valid_o   = sel ? data_valid_i : cfg_valid_i;
  assign cfg_ready_o  = !sel && tx_ready_i;
  assign data_ready_o = sel && tx_ready_i;

  // ----------------------------------------------------------------------
  // message lock and round-robin pointer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q   <= 1'b0;
      lock_src_q <= 1'b0;
      prio_q     <= 1'b0;
    end else if (tx_valid_o) begin
      if (tx_ready_i && tx_o.last) begin
        // message done, other source goes first next time
        locked_q <= 1'b0;
        prio_q   <= ~sel;
      end else begin
        // stalled or mid-message, keep the grant
        locked_q   <= 1'b1;
        lock_src_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/xdma_rx_demux.sv
// incoming beat steering
// decodes the local cfg and data mailbox windows, drops beats outside both

`timescale 1ns/10ps
`default_nettype none

`include "xdma_defs.svh"

module xdma_rx_demux (
  input  xdma_pkg::addr_t cluster_base_addr_i,
  input  xdma_pkg::beat_t rx_i,
  input  logic            rx_valid_i,
  output logic            rx_ready_o,
  output xdma_pkg::word_t rx_cfg_o,
  output xdma_pkg::word_t rx_data_o,
  output logic            rx_cfg_valid_o,
  output logic            rx_data_valid_o,
  input  logic            rx_cfg_ready_i,
  input  logic            rx_data_ready_i
);
  import xdma_pkg::*;

  addr_t local_end;
  addr_t cfg_start;
  addr_t data_start;
  logic  hit_cfg;
  logic  hit_data;

  // ----------------------------------------------------------------------
  // local windows
  // ----------------------------------------------------------------------
  // main memory owns the top of the 32-bit space
  assign local_end = (cluster_base_addr_i == `XDMA_MAINMEM_BASE) ? `XDMA_MAINMEM_END :
                     cluster_base_addr_i + `XDMA_CLUSTER_SPACE;
  assign data_start = local_end - addr_t'(`XDMA_SLOT_BYTES);
  assign cfg_start  = local_end - addr_t'(2 * `XDMA_SLOT_BYTES);

  assign hit_cfg  = (rx_i.addr >= cfg_start) && (rx_i.addr < data_start);
  assign hit_data = (rx_i.addr >= data_start) && (rx_i.addr < local_end);

  // ----------------------------------------------------------------------
  // routing
  // ----------------------------------------------------------------------
  assign rx_cfg_o        = rx_i.data;
  assign rx_data_o       = rx_i.data;
  assign rx_cfg_valid_o  = rx_valid_i && hit_cfg;
  assign rx_data_valid_o = rx_valid_i && hit_data;

  always_comb begin
    if (hit_cfg) begin
      rx_ready_o = rx_cfg_ready_i;
    end else if (hit_data) begin
      rx_ready_o = rx_data_ready_i;
    end else begin
      // unmatched, acknowledge and drop
      rx_ready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/xdma_adapter_top.sv
// inter-cluster dma adapter top
// outgoing cfg and data framing merged onto tx, incoming beats split by mailbox

`timescale 1ns/10ps
`default_nettype none

module xdma_adapter_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  xdma_pkg::addr_t     cluster_base_addr_i,
  // outgoing configuration
  input  xdma_pkg::word_t     cfg_i,
  input  logic                cfg_valid_i,
  output logic                cfg_ready_o,
  // outgoing payload
  input  xdma_pkg::word_t     data_i,
  input  xdma_pkg::data_cfg_t data_cfg_i,
  input  logic                data_valid_i,
  output logic                data_ready_o,
  // merged write beats
  output xdma_pkg::beat_t     tx_o,
  output logic                tx_valid_o,
  input  logic                tx_ready_i,
  // incoming write beats
  input  xdma_pkg::beat_t     rx_i,
  input  logic                rx_valid_i,
  output logic                rx_ready_o,
  output xdma_pkg::word_t     rx_cfg_o,
  output xdma_pkg::word_t     rx_data_o,
  output logic                rx_cfg_valid_o,
  output logic                rx_data_valid_o,
  input  logic                rx_cfg_ready_i,
  input  logic                rx_data_ready_i
);
  import xdma_pkg::*;

  beat_t cfg_beat;
  logic  cfg_beat_valid;
  logic  cfg_beat_ready;
  beat_t data_beat;
  logic  data_beat_valid;
  logic  data_beat_ready;

  // ----------------------------------------------------------------------
  // outgoing path
  // ----------------------------------------------------------------------
  xdma_cfg_framer i_cfg_framer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_ready_o  (cfg_ready_o),
    .beat_o       (cfg_beat),
    .beat_valid_o (cfg_beat_valid),
    .beat_ready_i (cfg_beat_ready)
  );

  xdma_data_framer i_data_framer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_i       (data_i),
    .data_cfg_i   (data_cfg_i),
    .data_valid_i (data_valid_i),
    .data_ready_o (data_ready_o),
    .beat_o       (data_beat),
    .beat_valid_o (data_beat_valid),
    .beat_ready_i (data_beat_ready)
  );

  // one message at a time onto tx
  xdma_tx_arbiter i_tx_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_beat_i   (cfg_beat),
    .data_beat_i  (data_beat),
    .cfg_valid_i  (cfg_beat_valid),
    .data_valid_i (data_beat_valid),
    .cfg_ready_o  (cfg_beat_ready),
    .data_ready_o (data_beat_ready),
    .tx_o         (tx_o),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i)
  );

  // ----------------------------------------------------------------------
  // incoming path
  // ----------------------------------------------------------------------
  xdma_rx_demux i_rx_demux (
    .cluster_base_addr_i (cluster_base_addr_i),
    .rx_i                (rx_i),
    .rx_valid_i          (rx_valid_i),
    .rx_ready_o          (rx_ready_o),
    .rx_cfg_o            (rx_cfg_o),
    .rx_data_o           (rx_data_o),
    .rx_cfg_valid_o      (rx_cfg_valid_o),
    .rx_data_valid_o     (rx_data_valid_o),
    .rx_cfg_ready_i      (rx_cfg_ready_i),
    .rx_data_ready_i     (rx_data_ready_i)
  );

endmodule

`default_nettype wire

// File: testbench/xdma_adapter_props.sv
// tx handshake properties of the xdma adapter
// valid held under stall, stable beat, one message at a time

`timescale 1ns/10ps
`default_nettype none

module xdma_adapter_props (
  input logic            clk_i,
  input logic            rst_ni,
  input xdma_pkg::beat_t tx_i,
  input logic            tx_valid_i,
  input logic            tx_ready_i
);
  import xdma_pkg::*;

  logic        in_msg_q;
  addr_t       msg_addr_q;
  // failed assertions so far
  int unsigned fail_cnt = 0;

  // mailbox of the message in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_msg_q   <= 1'b0;
      msg_addr_q <= '0;
    end else if (tx_valid_i && tx_ready_i) begin
      in_msg_q   <= !tx_i.last;
      msg_addr_q <= tx_i.addr;
    end
  end

  valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_valid_i && !tx_ready_i |=> tx_valid_i)
    else begin
      fail_cnt++;
      $error("tx valid dropped while stalled");
    end

  beat_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_valid_i && !tx_ready_i |=> $stable(tx_i))
    else begin
      fail_cnt++;
      $error("tx beat changed while stalled");
    end

  // another mailbox mid-message means interleaving
  no_interleave: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_msg_q && tx_valid_i |-> tx_i.addr == msg_addr_q)
    else begin
      fail_cnt++;
      $error("tx message interleaved");
    end

endmodule

bind xdma_adapter_top xdma_adapter_props props0 (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .tx_i       (tx_o),
  .tx_valid_i (tx_valid_o),
  .tx_ready_i (tx_ready_i)
);

`default_nettype wire

// File: testbench/tb_xdma_adapter.sv
// xdma adapter testbench
// table-driven cfg and payload messages merged under random tx stall, then rx steering

`timescale 1ns/10ps
`default_nettype none

`include "xdma_defs.svh"

module tb_xdma_adapter;
  import xdma_pkg::*;

  localparam int NMSG = 10;
  localparam int NRX  = 10;
  // remote address that no table target shares, exposes a wrong dma_type pick
  localparam addr_t DECOY = 48'h0000_1ff0_0000;

  // one outgoing message, dir only matters for cfg
  typedef struct packed {
    logic        is_data;
    addr_t       target;
    logic        dir;
    len_t        len;
    logic [15:0] seed;
  } msg_t;

  // one incoming beat, kind 0 cfg window, 1 data window, 2 outside
  typedef struct packed {
    addr_t      base;
    addr_t      addr;
    logic [1:0] kind;
    logic       stall;
  } rx_vec_t;

  logic      clk;
  logic      rst_n;
  addr_t     cluster_base;
  word_t     cfg_word;
  logic      cfg_valid;
  logic      cfg_ready;
  word_t     data_word;
  data_cfg_t data_cfg;
  logic      data_valid;
  logic      data_ready;
  beat_t     tx;
  logic      tx_valid;
  logic      tx_ready;
  beat_t     rx_beat;
  logic      rx_valid;
  logic      rx_ready;
  word_t     rx_cfg;
  word_t     rx_data;
  logic      rx_cfg_valid;
  logic      rx_data_valid;
  logic      rx_cfg_ready;
  logic      rx_data_ready;

  msg_t    msg_tbl [0:NMSG-1];
  rx_vec_t rx_tbl [0:NRX-1];
  beat_t   cfg_exp [$];
  beat_t   data_exp [$];
  beat_t   exp_beat;
  logic    in_msg;
  logic    cur_cfg;
  int      checks;
  int      errors;
  int      cycles;
  int      cycle_limit;

  xdma_adapter_top dut0 (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .cluster_base_addr_i (cluster_base),
    .cfg_i               (cfg_word),
    .cfg_valid_i         (cfg_valid),
    .cfg_ready_o         (cfg_ready),
    .data_i              (data_word),
    .data_cfg_i          (data_cfg),
    .data_valid_i        (data_valid),
    .data_ready_o        (data_ready),
    .tx_o                (tx),
    .tx_valid_o          (tx_valid),
    .tx_ready_i          (tx_ready),
    .rx_i                (rx_beat),
    .rx_valid_i          (rx_valid),
    .rx_ready_o          (rx_ready),
    .rx_cfg_o            (rx_cfg),
    .rx_data_o           (rx_data),
    .rx_cfg_valid_o      (rx_cfg_valid),
    .rx_data_valid_o     (rx_data_valid),
    .rx_cfg_ready_i      (rx_cfg_ready),
    .rx_data_ready_i     (rx_data_ready)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // cluster windows are aligned, so the top is the next cluster boundary
  function automatic addr_t expected_mailbox(addr_t target, logic is_cfg);
    addr_t top;
    if (target >= `XDMA_MAINMEM_BASE) begin
      top = `XDMA_MAINMEM_END;
    end else begin
      top = {target[47:20] + 28'd1, 20'h0_0000};
    end
    return top - (is_cfg ? 48'h2000 : 48'h1000);
  endfunction

  function automatic int msg_beats(msg_t m);
    return (m.len <= 1) ? 1 : int'(m.len);
  endfunction

  function automatic word_t make_word(logic [15:0] seed, int k);
    return {4{seed, 16'(k)}};
  endfunction

  function automatic word_t make_header(msg_t m);
    cfg_header_t h;
    h.pad          = 7'h2a;
    h.reader_addr  = m.dir ? DECOY : m.target;
    h.writer_addr  = m.dir ? m.target : DECOY;
    h.dma_id       = m.seed[7:0];
    h.frame_length = m.len;
    h.dma_type     = m.dir;
    return word_t'(h);
  endfunction

  task automatic check_value(input string name, input logic [$bits(beat_t)-1:0] got,
                             input logic [$bits(beat_t)-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // expected tx beats per stream, in table order
  task automatic build_expected();
    msg_t  m;
    beat_t b;
    for (int i = 0; i < NMSG; i++) begin
      m = msg_tbl[i];
      for (int k = 0; k < msg_beats(m); k++) begin
        b.addr = expected_mailbox(m.target, !m.is_data);
        b.data = (!m.is_data && k == 0) ? make_header(m) : make_word(m.seed, k);
        b.last = (k == msg_beats(m) - 1);
        if (m.is_data) begin
          data_exp.push_back(b);
        end else begin
          cfg_exp.push_back(b);
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic send_cfg_msgs();
    msg_t m;
    for (int i = 0; i < NMSG; i++) begin
      m = msg_tbl[i];
      for (int k = 0; k < msg_beats(m) && !m.is_data; k++) begin
        cfg_word  = (k == 0) ? make_header(m) : make_word(m.seed, k);
        cfg_valid = 1'b1;
        @(posedge clk);
        while (!cfg_ready) @(posedge clk);
        @(negedge clk);
      end
    end
    cfg_valid = 1'b0;
  endtask

  // sideband set with the first beat, held to the last
  task automatic send_data_msgs();
    msg_t m;
    for (int i = 0; i < NMSG; i++) begin
      m = msg_tbl[i];
      for (int k = 0; k < msg_beats(m) && m.is_data; k++) begin
        data_cfg.dst_addr   = m.target;
        data_cfg.dma_length = m.len;
        data_word           = make_word(m.seed, k);
        data_valid          = 1'b1;
        @(posedge clk);
        while (!data_ready) @(posedge clk);
        @(negedge clk);
      end
    end
    data_valid = 1'b0;
  endtask

  // non-stall: only the target window ready; stall: both low
  task automatic run_rx_vectors();
    rx_vec_t v;
    word_t   w;
    for (int i = 0; i < NRX; i++) begin
      v             = rx_tbl[i];
      w             = make_word(16'h5000 + 16'(i), i);
      cluster_base  = v.base;
      rx_beat.addr  = v.addr;
      rx_beat.data  = w;
      rx_beat.last  = 1'b1;
      rx_valid      = 1'b1;
      rx_cfg_ready  = !v.stall && (v.kind == 2'd0);
      rx_data_ready = !v.stall && (v.kind == 2'd1);
      @(posedge clk);
      check_value("rx_cfg_valid_o", rx_cfg_valid, v.kind == 2'd0);
      check_value("rx_data_valid_o", rx_data_valid, v.kind == 2'd1);
      check_value("rx_ready_o", rx_ready, (v.kind == 2'd2) || !v.stall);
      if (v.kind == 2'd0) begin
        check_value("rx_cfg_o", rx_cfg, w);
      end else if (v.kind == 2'd1) begin
        check_value("rx_data_o", rx_data, w);
      end
      @(negedge clk);
    end
    rx_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // clock, stall source, timeout
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // first call seeds the generator, ready high about 3 cycles in 4
  initial begin
    tx_ready = $urandom(32'h3203_b85b) % 2;
    forever begin
      @(negedge clk);
      tx_ready = ($urandom % 4) != 0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, traffic did not complete", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // tx monitor
  // ----------------------------------------------------------------------
  // stream picked at the first beat of a message, then held until last
  always @(posedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      if (!in_msg) begin
        cur_cfg = (cfg_exp.size() != 0) && (tx === cfg_exp[0]);
      end
      if ((cur_cfg && cfg_exp.size() == 0) || (!cur_cfg && data_exp.size() == 0)) begin
        errors++;
        $display("ERROR t=%0t tx beat arrived with no message pending", $time);
      end else begin
        if (cur_cfg) begin
          exp_beat = cfg_exp.pop_front();
        end else begin
          exp_beat = data_exp.pop_front();
        end
        check_value("tx_o.addr", tx.addr, exp_beat.addr);
        check_value("tx_o.data", tx.data, exp_beat.data);
        check_value("tx_o.last", tx.last, exp_beat.last);
      end
      in_msg = !tx.last;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int total;
    checks        = 0;
    errors        = 0;
    cycles        = 0;
    in_msg        = 1'b0;
    cur_cfg       = 1'b0;
    rst_n         = 1'b0;
    cluster_base  = 48'h0000_1040_0000;
    cfg_word      = '0;
    cfg_valid     = 1'b0;
    data_word     = '0;
    data_cfg      = '0;
    data_valid    = 1'b0;
    rx_beat       = '0;
    rx_valid      = 1'b0;
    rx_cfg_ready  = 1'b1;
    rx_data_ready = 1'b1;

    // data flag, target, dir, length, seed
    msg_tbl[0] = {1'b0, 48'h0000_1030_0040, 1'b0, 16'd1, 16'h0011};
    msg_tbl[1] = {1'b1, 48'h0000_1050_2000, 1'b0, 16'd3, 16'h0021};
    msg_tbl[2] = {1'b0, 48'h0000_1010_0800, 1'b1, 16'd4, 16'h0012};
    msg_tbl[3] = {1'b0, 48'h0000_1070_0000, 1'b0, 16'd4, 16'h0013};
    msg_tbl[4] = {1'b1, 48'h0000_8000_1000, 1'b0, 16'd2, 16'h0022};
    msg_tbl[5] = {1'b0, 48'h0000_9000_0000, 1'b1, 16'd0, 16'h0014};
    msg_tbl[6] = {1'b1, 48'h0000_1000_0010, 1'b0, 16'd5, 16'h0023};
    msg_tbl[7] = {1'b0, 48'h0000_1020_0000, 1'b0, 16'd3, 16'h0015};
    msg_tbl[8] = {1'b1, 48'h0000_1120_0000, 1'b0, 16'd1, 16'h0024};
    msg_tbl[9] = {1'b1, 48'h0000_c000_0000, 1'b0, 16'd0, 16'h0025};

    // base, beat address, window kind, stall
    rx_tbl[0] = {48'h0000_1040_0000, 48'h0000_104f_e000, 2'd0, 1'b0};
    rx_tbl[1] = {48'h0000_1040_0000, 48'h0000_104f_eff0, 2'd0, 1'b1};
    rx_tbl[2] = {48'h0000_1040_0000, 48'h0000_104f_f000, 2'd1, 1'b0};
    rx_tbl[3] = {48'h0000_1040_0000, 48'h0000_104f_fff0, 2'd1, 1'b1};
    rx_tbl[4] = {48'h0000_1040_0000, 48'h0000_104f_d000, 2'd2, 1'b0};
    rx_tbl[5] = {48'h0000_1040_0000, 48'h0000_1050_f000, 2'd2, 1'b1};
    rx_tbl[6] = {48'h0000_8000_0000, 48'h0000_ffff_e100, 2'd0, 1'b0};
    rx_tbl[7] = {48'h0000_8000_0000, 48'h0000_ffff_f800, 2'd1, 1'b1};
    rx_tbl[8] = {48'h0000_8000_0000, 48'h0000_ffff_d000, 2'd2, 1'b0};
    rx_tbl[9] = {48'h0000_8000_0000, 48'h0001_0000_0000, 2'd2, 1'b1};

    total = NRX;
    for (int i = 0; i < NMSG; i++) begin
      total += msg_beats(msg_tbl[i]);
    end
    cycle_limit = 40 * total + 200;
    build_expected();

    repeat (5) @(negedge clk);
    check_value("tx_valid_o", tx_valid, 1'b0);
    check_value("rx_cfg_valid_o", rx_cfg_valid, 1'b0);
    check_value("rx_data_valid_o", rx_data_valid, 1'b0);
    rst_n = 1'b1;

    // both streams offered together
    fork
      send_cfg_msgs();
      send_data_msgs();
    join
    while (cfg_exp.size() != 0 || data_exp.size() != 0) @(negedge clk);

    run_rx_vectors();

    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut0.props0.fail_cnt);
    if (errors == 0 && dut0.props0.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/xdma_pkg.sv
logic/xdma_cfg_framer.sv
logic/xdma_data_framer.sv
logic/xdma_tx_arbiter.sv
logic/xdma_rx_demux.sv
logic/xdma_adapter_top.sv
testbench/xdma_adapter_props.sv
testbench/tb_xdma_adapter.sv

// File: Bender.yml
package:
  name: xdma_adapter

sources:
  - include_dirs:
      - logic
    files:
      - logic/xdma_pkg.sv
      - logic/xdma_cfg_framer.sv
      - logic/xdma_data_framer.sv
      - logic/xdma_tx_arbiter.sv
      - logic/xdma_rx_demux.sv
      - logic/xdma_adapter_top.sv
      - target: test
        files:
          - testbench/xdma_adapter_props.sv
          - testbench/tb_xdma_adapter.sv
